// File: rtl/rv_isa_pkg.sv
package rv_isa_pkg;

  // word and address width
  localparam int XLEN = 32;

  typedef logic [4:0] reg_idx_t;

  // only the major opcodes this core executes
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // funct3 for alu ops, shared by reg-reg and reg-imm forms
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // funct7, sub only differs in bit 30
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // offset bits are scattered, reassembled in decode
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  // one instruction word, three views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    b_fmt_t b;
  } instr_u;

endpackage

// File: rtl/rv_pipe_pkg.sv
package rv_pipe_pkg;

  import rv_isa_pkg::*;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  // fetch to decode
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;
  } if_id_t;

  // decode to execute
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    reg_idx_t        rs1_idx;
    reg_idx_t        rs2_idx;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm;
    // second operand from imm instead of rs2
    logic            use_imm;
    alu_op_e         alu_op;
    logic            is_branch;
    // bne when set, beq otherwise
    logic            bne;
    logic [XLEN-1:0] br_off;
    reg_idx_t        rd;
    logic            we;
  } id_ex_t;

  // register file write port and retire record
  typedef struct packed {
    logic            valid;
    logic            we;
    reg_idx_t        rd;
    logic [XLEN-1:0] data;
    logic [XLEN-1:0] pc;
  } wb_t;

  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target;
  } redirect_t;

endpackage

// File: rtl/rv_fetch.sv
module rv_fetch
  import rv_pipe_pkg::*;
#(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic        clk,
  input  logic        rst_i,
  input  redirect_t   redirect_i,
  output logic [31:0] imem_addr_o,
  input  logic [31:0] imem_data_i,
  output if_id_t      fetch_o
);

  logic [31:0] pc_q;

  // branch target wins over sequential step
  always_ff @(posedge clk) begin
    if (rst_i) begin
      pc_q <= RESET_PC;
    end else if (redirect_i.taken) begin
      pc_q <= redirect_i.target;
    end else begin
      pc_q <= pc_q + 32'd4;
    end
  end

  // memory read is combinational from the pc
  assign imem_addr_o = pc_q;

  // word on the wrong path while execute redirects
  assign fetch_o.valid = ~redirect_i.taken;
  assign fetch_o.pc    = pc_q;
  assign fetch_o.instr = imem_data_i;

endmodule

// File: rtl/rv_regfile.sv
module rv_regfile
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  logic            clk,
  input  logic            rst_i,
  input  reg_idx_t        rs1_idx_i,
  input  reg_idx_t        rs2_idx_i,
  output logic [XLEN-1:0] rs1_data_o,
  output logic [XLEN-1:0] rs2_data_o,
  input  wb_t             wr_i
);

  // x0 has no storage
  logic [XLEN-1:0] regs_q [1:31];
  logic            wr_en;

  assign wr_en = wr_i.valid & wr_i.we & (wr_i.rd != '0);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wr_i.rd] <= wr_i.data;
    end
  end

  // same-cycle write shows through to the reader
  function automatic logic [XLEN-1:0] read_port(reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (wr_en && wr_i.rd == idx) begin
      return wr_i.data;
    end
    return regs_q[idx];
  endfunction

  assign rs1_data_o = read_port(rs1_idx_i);
  assign rs2_data_o = read_port(rs2_idx_i);

endmodule

// File: rtl/rv_decode.sv
module rv_decode
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst_i,
  input  if_id_t    fetch_i,
  input  redirect_t redirect_i,
  input  wb_t       wb_i,
  output id_ex_t    decode_o
);

  if_id_t          if_id_q;
  instr_u          ins;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;

  // IF/ID, only valid sees reset and flush
  always_ff @(posedge clk) begin
    if_id_q.pc    <= fetch_i.pc;
    if_id_q.instr <= fetch_i.instr;
    if (rst_i) begin
      if_id_q.valid <= 1'b0;
    end else begin
      if_id_q.valid <= fetch_i.valid & ~redirect_i.taken;
    end
  end

  assign ins = if_id_q.instr;

  rv_regfile u_regfile (
    .clk        (clk),
    .rst_i      (rst_i),
    .rs1_idx_i  (ins.r.rs1),
    .rs2_idx_i  (ins.r.rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wr_i       (wb_i)
  );

  // funct3 codes with an alu op behind them
  function automatic logic f3_known(logic [2:0] f3);
    return f3 inside {F3_ADD_SUB, F3_SLT, F3_XOR, F3_OR, F3_AND};
  endfunction

  function automatic alu_op_e alu_from_f3(logic [2:0] f3, logic sub);
    case (f3)
      F3_ADD_SUB: return sub ? ALU_SUB : ALU_ADD;
      F3_SLT:     return ALU_SLT;
      F3_XOR:     return ALU_XOR;
      F3_OR:      return ALU_OR;
      F3_AND:     return ALU_AND;
      default:    return ALU_ADD;
    endcase
  endfunction

  always_comb begin
    decode_o          = '0;
    decode_o.valid    = if_id_q.valid;
    decode_o.pc       = if_id_q.pc;
    decode_o.rs1_idx  = ins.r.rs1;
    decode_o.rs2_idx  = ins.r.rs2;
    decode_o.rs1_data = rs1_data;
    decode_o.rs2_data = rs2_data;
    decode_o.rd       = ins.r.rd;
    // same word read as i-type and as b-type
    decode_o.imm      = {{20{ins.i.imm[11]}}, ins.i.imm};
    decode_o.br_off   = {{19{ins.b.imm12}}, ins.b.imm12, ins.b.imm11,
                         ins.b.imm10_5, ins.b.imm4_1, 1'b0};
    case (ins.r.opcode)
      OPC_OP: begin
        decode_o.alu_op = alu_from_f3(ins.r.funct3, ins.r.funct7 == F7_SUB);
        // sub is the only funct7 variant kept
        decode_o.we     = f3_known(ins.r.funct3) &&
                          (ins.r.funct7 == F7_BASE ||
                           (ins.r.funct7 == F7_SUB && ins.r.funct3 == F3_ADD_SUB));
      end
      OPC_OP_IMM: begin
        decode_o.use_imm = 1'b1;
        decode_o.alu_op  = alu_from_f3(ins.i.funct3, 1'b0);
        decode_o.we      = f3_known(ins.i.funct3);
      end
      OPC_BRANCH: begin
        decode_o.is_branch = ins.b.funct3 inside {F3_BEQ, F3_BNE};
        decode_o.bne       = ins.b.funct3 == F3_BNE;
      end
      // anything else passes through as a no-op
      default: ;
    endcase
    // x0 is never written
    if (ins.r.rd == '0) begin
      decode_o.we = 1'b0;
    end
  end

endmodule

// File: rtl/rv_execute.sv
module rv_execute
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst_i,
  input  id_ex_t    decode_i,
  output redirect_t redirect_o,
  output wb_t       wb_o
);

  id_ex_t          ex_q;
  wb_t             wb_q;
  logic            fwd_rs1;
  logic            fwd_rs2;
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_res;
  logic            rs_eq;

  // ID/EX, drop the younger item when this stage redirects
  always_ff @(posedge clk) begin
    ex_q.pc        <= decode_i.pc;
    ex_q.rs1_idx   <= decode_i.rs1_idx;
    ex_q.rs2_idx   <= decode_i.rs2_idx;
    ex_q.rs1_data  <= decode_i.rs1_data;
    ex_q.rs2_data  <= decode_i.rs2_data;
    ex_q.imm       <= decode_i.imm;
    ex_q.use_imm   <= decode_i.use_imm;
    ex_q.alu_op    <= decode_i.alu_op;
    ex_q.is_branch <= decode_i.is_branch;
    ex_q.bne       <= decode_i.bne;
    ex_q.br_off    <= decode_i.br_off;
    ex_q.rd        <= decode_i.rd;
    ex_q.we        <= decode_i.we;
    if (rst_i) begin
      ex_q.valid <= 1'b0;
    end else begin
      ex_q.valid <= decode_i.valid & ~redirect_o.taken;
    end
  end

  // EX/WB holds the one producer still missing from the regfile read
  assign fwd_rs1 = wb_q.valid & wb_q.we & (wb_q.rd != '0) & (wb_q.rd == ex_q.rs1_idx);
  assign fwd_rs2 = wb_q.valid & wb_q.we & (wb_q.rd != '0) & (wb_q.rd == ex_q.rs2_idx);
  assign rs1_val = fwd_rs1 ? wb_q.data : ex_q.rs1_data;
  assign rs2_val = fwd_rs2 ? wb_q.data : ex_q.rs2_data;
  assign op_b    = ex_q.use_imm ? ex_q.imm : rs2_val;

  always_comb begin
    case (ex_q.alu_op)
      ALU_SUB: alu_res = rs1_val - op_b;
      ALU_AND: alu_res = rs1_val & op_b;
      ALU_OR:  alu_res = rs1_val | op_b;
      ALU_XOR: alu_res = rs1_val ^ op_b;
      ALU_SLT: alu_res = {31'b0, $signed(rs1_val) < $signed(op_b)};
      default: alu_res = rs1_val + op_b;
    endcase
  end

  // branch compare always on the two registers
  assign rs_eq             = rs1_val == rs2_val;
  assign redirect_o.taken  = ex_q.valid & ex_q.is_branch & (ex_q.bne ? ~rs_eq : rs_eq);
  assign redirect_o.target = ex_q.pc + ex_q.br_off;

  // EX/WB, valid and we cleared on reset
  always_ff @(posedge clk) begin
    wb_q.rd   <= ex_q.rd;
    wb_q.data <= alu_res;
    wb_q.pc   <= ex_q.pc;
    if (rst_i) begin
      wb_q.valid <= 1'b0;
      wb_q.we    <= 1'b0;
    end else begin
      wb_q.valid <= ex_q.valid;
      // branches carry we low from decode
      wb_q.we    <= ex_q.valid & ex_q.we;
    end
  end

  assign wb_o = wb_q;

endmodule

// File: rtl/rv_core.sv
module rv_core
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;
#(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic        clk,
  input  logic        rst_i,
  output logic [31:0] imem_addr_o,
  input  logic [31:0] imem_data_i,
  output logic        retire_valid_o,
  output logic        retire_we_o,
  output logic [31:0] retire_pc_o,
  output reg_idx_t    retire_rd_o,
  output logic [31:0] retire_data_o
);

  if_id_t    fetch;
  id_ex_t    decode;
  redirect_t redirect;
  wb_t       wb;

  rv_fetch #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk         (clk),
    .rst_i       (rst_i),
    .redirect_i  (redirect),
    .imem_addr_o (imem_addr_o),
    .imem_data_i (imem_data_i),
    .fetch_o     (fetch)
  );

  rv_decode u_decode (
    .clk        (clk),
    .rst_i      (rst_i),
    .fetch_i    (fetch),
    .redirect_i (redirect),
    .wb_i       (wb),
    .decode_o   (decode)
  );

  rv_execute u_execute (
    .clk        (clk),
    .rst_i      (rst_i),
    .decode_i   (decode),
    .redirect_o (redirect),
    .wb_o       (wb)
  );

  // retire record is the regfile write itself
  assign retire_valid_o = wb.valid;
  assign retire_we_o    = wb.we;
  assign retire_pc_o    = wb.pc;
  assign retire_rd_o    = wb.rd;
  assign retire_data_o  = wb.data;

endmodule

// File: tests/rv_core_ref.sv
module rv_core_ref
  import rv_isa_pkg::*;
#(
  parameter logic [31:0] BASE     = 32'h0,
  parameter int          PROG_LEN = 200
) (
  input  logic [31:0] addr_i,
  output logic [31:0] data_o
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] prog     [PROG_LEN];
  // expected retire sequence, one entry per executed instruction
  logic [31:0] exp_pc   [PROG_LEN];
  logic        exp_we   [PROG_LEN];
  reg_idx_t    exp_rd   [PROG_LEN];
  logic [31:0] exp_data [PROG_LEN];
  int          exp_count;
  integer      seed;

  // past the program: addi x0 with an immediate folded from the address
  function automatic logic [31:0] fill_word(logic [31:0] a);
    logic [11:0] imm;
    imm = a[11:0] ^ a[23:12] ^ {4'h0, a[31:24]};
    return {imm, 5'd0, F3_ADD_SUB, 5'd0, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] word_at(logic [31:0] a);
    logic [31:0] idx;
    idx = (a - BASE) >> 2;
    return (idx < PROG_LEN) ? prog[idx] : fill_word(a);
  endfunction

  // combinational instruction memory
  assign data_o = word_at(addr_i);

  function automatic int rand_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // x0..x7 only, so dependencies are dense
  function automatic reg_idx_t pick_reg();
    return reg_idx_t'(rand_below(8));
  endfunction

  function automatic logic [2:0] pick_f3(int sel);
    case (sel)
      0:       return F3_ADD_SUB;
      1:       return F3_SLT;
      2:       return F3_XOR;
      3:       return F3_OR;
      default: return F3_AND;
    endcase
  endfunction

  // rv32i semantics of the kept alu ops
  function automatic logic [31:0] model_alu(logic [2:0] f3, logic sub, logic [31:0] a,
                                            logic [31:0] b);
    case (f3)
      F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_XOR:  return a ^ b;
      F3_OR:   return a | b;
      F3_AND:  return a & b;
      default: return sub ? a - b : a + b;
    endcase
  endfunction

  task automatic build_program(input integer start_seed);
    b_fmt_t      br;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [2:0]  f3;
    logic [12:0] off;
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] nxt;
    logic        we;
    int          k;
    int          sel;
    seed = start_seed;
    for (int i = 0; i < PROG_LEN; i++) begin
      k   = rand_below(100);
      rd  = pick_reg();
      rs1 = pick_reg();
      rs2 = pick_reg();
      if (k < 5) begin
        // load/store opcodes, not executed here
        prog[i] = $random(seed);
        prog[i][6:0] = rand_below(2) ? 7'b0000011 : 7'b0100011;
      end else if (k < 17 && i < PROG_LEN - 4) begin
        // forward 8, 12 or 16 bytes, never past the program
        off = 13'(8 + 4 * rand_below(3));
        br = '0;
        br.opcode  = OPC_BRANCH;
        br.funct3  = rand_below(2) ? F3_BNE : F3_BEQ;
        br.rs1     = rs1;
        br.rs2     = rs2;
        br.imm12   = off[12];
        br.imm11   = off[11];
        br.imm10_5 = off[10:5];
        br.imm4_1  = off[4:1];
        prog[i] = br;
      end else if (k < 55) begin
        // sel 5 is sub
        sel = rand_below(6);
        f3  = (sel == 5) ? F3_ADD_SUB : pick_f3(sel);
        prog[i] = {(sel == 5) ? F7_SUB : F7_BASE, rs2, rs1, f3, rd, OPC_OP};
      end else begin
        prog[i] = {12'($random(seed)), rs1, pick_f3(rand_below(5)), rd, OPC_OP_IMM};
      end
    end
    // in-order walk of the program
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    pc = BASE;
    exp_count = 0;
    while (pc - BASE < 4 * PROG_LEN) begin
      w   = prog[(pc - BASE) >> 2];
      a   = regs[w[19:15]];
      b   = regs[w[24:20]];
      we  = 1'b0;
      res = '0;
      nxt = pc + 4;
      case (w[6:0])
        OPC_OP: begin
          we  = 1'b1;
          res = model_alu(w[14:12], w[30], a, b);
        end
        OPC_OP_IMM: begin
          we  = 1'b1;
          res = model_alu(w[14:12], 1'b0, a, {{20{w[31]}}, w[31:20]});
        end
        OPC_BRANCH: begin
          if ((w[14:12] == F3_BNE) ? (a != b) : (a == b)) begin
            nxt = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
          end
        end
        default: ;
      endcase
      // x0 stays zero
      if (w[11:7] == 5'd0) begin
        we = 1'b0;
      end
      if (we) begin
        regs[w[11:7]] = res;
      end
      exp_pc[exp_count]   = pc;
      exp_we[exp_count]   = we;
      exp_rd[exp_count]   = w[11:7];
      exp_data[exp_count] = res;
      exp_count++;
      pc = nxt;
    end
  endtask

endmodule

// File: tests/rv_core_tb.sv
module rv_core_tb
  import rv_isa_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] RESET_PC   = 32'h0;
  localparam int          PROG_LEN   = 200;
  localparam int          MAX_CYCLES = 4 * PROG_LEN + 60;
  localparam int          SEED       = 28196;

  logic        clk;
  logic        rst_i;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic        retire_valid;
  logic        retire_we;
  logic [31:0] retire_pc;
  reg_idx_t    retire_rd;
  logic [31:0] retire_data;
  // fetch address seen in each cycle after reset
  logic [31:0] addr_hist [MAX_CYCLES + 1];
  int          cycle;
  int          exp_idx;

  rv_core #(
    .RESET_PC (RESET_PC)
  ) dut (
    .clk            (clk),
    .rst_i          (rst_i),
    .imem_addr_o    (imem_addr),
    .imem_data_i    (imem_data),
    .retire_valid_o (retire_valid),
    .retire_we_o    (retire_we),
    .retire_pc_o    (retire_pc),
    .retire_rd_o    (retire_rd),
    .retire_data_o  (retire_data)
  );

  // program memory and expected retire sequence
  rv_core_ref #(
    .BASE     (RESET_PC),
    .PROG_LEN (PROG_LEN)
  ) ref_model (
    .addr_i (imem_addr),
    .data_o (imem_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic fail_run();
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
    $display("ERROR at %0d ns: %s expected %h, got %h", $time, name, exp, act);
    fail_run();
  endtask

  task automatic report_problem(string what);
    $display("%s at %0d ns", what, $time);
    fail_run();
  endtask

  task automatic check_idle_retire();
    assert (retire_valid === 1'b0)
      else report_mismatch("retire_valid_o", 32'd0, 32'(retire_valid));
    assert (retire_we === 1'b0)
      else report_mismatch("retire_we_o", 32'd0, 32'(retire_we));
  endtask

  task automatic check_retire();
    int k;
    k = exp_idx;
    // in-order pc also covers taken and not-taken branch successors
    assert (retire_pc === ref_model.exp_pc[k])
      else report_mismatch("retire_pc_o", ref_model.exp_pc[k], retire_pc);
    assert (retire_we === ref_model.exp_we[k])
      else report_mismatch("retire_we_o", 32'(ref_model.exp_we[k]), 32'(retire_we));
    // rd and data only mean something on a register write
    if (ref_model.exp_we[k]) begin
      assert (retire_rd === ref_model.exp_rd[k])
        else report_mismatch("retire_rd_o", 32'(ref_model.exp_rd[k]), 32'(retire_rd));
      assert (retire_data === ref_model.exp_data[k])
        else report_mismatch("retire_data_o", ref_model.exp_data[k], retire_data);
    end
    // three cycles from fetch to retire, flushed items never show up
    assert (retire_pc === addr_hist[cycle - 3])
      else report_mismatch("retire_pc_o vs fetch address", addr_hist[cycle - 3], retire_pc);
    exp_idx++;
  endtask

  initial begin
    rst_i   = 1'b1;
    cycle   = 0;
    exp_idx = 0;
    ref_model.build_program(SEED);
    // 10 reset cycles, first posedge at 20 ns
    repeat (10) begin
      @(negedge clk);
      check_idle_retire();
      assert (imem_addr === RESET_PC)
        else report_mismatch("imem_addr_o", RESET_PC, imem_addr);
    end
    rst_i = 1'b0;
    addr_hist[0] = imem_addr;
    while (exp_idx < ref_model.exp_count) begin
      @(negedge clk);
      cycle++;
      if (cycle > MAX_CYCLES) begin
        report_problem("timeout, the expected retire sequence did not complete");
      end
      addr_hist[cycle] = imem_addr;
      // nothing retires right after reset
      if (cycle == 1) begin
        check_idle_retire();
      end
      if (retire_valid === 1'b1) begin
        check_retire();
      end
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: rv_core.f
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/rv_fetch.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_core.sv
tests/rv_core_ref.sv
tests/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - rtl/rv_isa_pkg.sv
  - rtl/rv_pipe_pkg.sv
  - rtl/rv_fetch.sv
  - rtl/rv_regfile.sv
  - rtl/rv_decode.sv
  - rtl/rv_execute.sv
  - rtl/rv_core.sv
  - target: test
    files:
      - tests/rv_core_ref.sv
      - tests/rv_core_tb.sv
